// File: verilog/spritePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants and types for the sprite core
// one pixel per clk, small test raster only
// palette and pattern contents are fixed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spritePkg;
    // tile geometry
    localparam int tileW = 8;
    localparam int tileH = 8;
    // raster, total and visible
    localparam int hTotal = 80;
    localparam int vTotal = 56;
    localparam int hActive = 64;
    localparam int vActive = 48;
    // sprite origin inside the visible area
    localparam int gameStartX = 4;
    localparam int gameStartY = 2;
    localparam int posBits = 7;
    // wide enough that a negative sprite offset never aliases into the box
    localparam int relBits = 10;
    localparam int spriteNum = 16;
    localparam int spriteIdxBits = 4;
    localparam int tileNum = 64;
    localparam int tileIdxBits = 6;
    localparam int tileDataBits = 128;
    localparam int rgbBits = 12;
    localparam int apbAddrBits = 8;
    localparam int apbDataBits = 32;
    localparam logic [apbAddrBits-1:0] regActiveAddr = 8'h40;
    localparam logic [rgbBits-1:0] bgColor = 12'h124;
    // palette p, code c at entry 3*p + c - 1
    localparam logic [rgbBits-1:0] paletteTable [0:11] = '{
        12'hF00, 12'h0F0, 12'h00F,
        12'hFF0, 12'h0FF, 12'hF0F,
        12'hF80, 12'h8F0, 12'h08F,
        12'hFFF, 12'h888, 12'h444
    };
    // pattern rule for tile t, column x, row y
    // code = (x + y + t) & 3
    // plane 1 keeps code bit 1 at 127 - (x + 8y)
    // plane 0 keeps code bit 0 at 63 - (x + 8y)
    typedef struct packed {
        logic [7:0] posX;
        logic [7:0] posY;
        logic [1:0] rsvdHi;
        logic [tileIdxBits-1:0] tileIdx;
        logic hFlip;
        logic vFlip;
        logic [1:0] palSel;
        logic [3:0] rsvdLo;
    } spriteFieldsT;
    typedef union packed {
        logic [apbDataBits-1:0] raw;
        spriteFieldsT fields;
    } spriteAttrT;
endpackage

// File: verilog/scanIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan position bus, no handshake
// values change every pixel clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
interface scanIf;
    import spritePkg::*;
    // raster coordinates, screen space
    logic [posBits-1:0] posX;
    logic [posBits-1:0] posY;
    // inside visible area
    logic active;
    // high for the 0,0 pixel only
    logic frameStart;
    modport source (output posX, output posY, output active, output frameStart);
    modport sink (input posX, input posY, input active, input frameStart);
endinterface

// File: verilog/scanPosGen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster counters, one pixel per clock
// no sync pulses, blanking is just active low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module scanPosGen (
    input logic clk,
    input logic rstn,
    scanIf.source scan
);
    import spritePkg::*;
    logic [posBits-1:0] hCnt;
    logic [posBits-1:0] vCnt;
    logic lineEnd;
    assign lineEnd = (hCnt == posBits'(hTotal - 1));
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (lineEnd) begin
            hCnt <= '0;
            // frame wrap on last line
            if (vCnt == posBits'(vTotal - 1)) begin
                vCnt <= '0;
            end else begin
                vCnt <= vCnt + 1'b1;
            end
        end else begin
            hCnt <= hCnt + 1'b1;
        end
    end
    assign scan.posX = hCnt;
    assign scan.posY = vCnt;
    assign scan.active = (hCnt < posBits'(hActive)) && (vCnt < posBits'(vActive));
    assign scan.frameStart = (hCnt == '0) && (vCnt == '0);
    // counters stay inside the raster
    assert property (@(posedge clk) disable iff (!rstn)
        (hCnt < posBits'(hTotal)) && (vCnt < posBits'(vTotal)))
        else $error("scan counter out of range %0d,%0d", hCnt, vCnt);
endmodule

// File: verilog/apbSpriteRegs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave, zero wait states, pready tied high
// reads need the setup phase, memory read is registered
// unaligned or above 0x40 gives pslverr, no write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module apbSpriteRegs (
    input  logic clk,
    input  logic rstn,
    input  logic [spritePkg::apbAddrBits-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [spritePkg::apbDataBits-1:0] pwdata,
    output logic [spritePkg::apbDataBits-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic wrEn,
    output logic [spritePkg::spriteIdxBits-1:0] wrIdx,
    output logic [spritePkg::apbDataBits-1:0] wrData,
    output logic [spritePkg::spriteIdxBits-1:0] rdIdx,
    input  logic [spritePkg::apbDataBits-1:0] rdData,
    output logic [spritePkg::spriteIdxBits-1:0] activeIdx
);
    import spritePkg::*;
    logic access;
    logic addrErr;
    logic isActive;
    // access phase of any transfer
    assign access = psel && penable;
    assign addrErr = (paddr[1:0] != 2'b00) || (paddr > regActiveAddr);
    assign isActive = (paddr == regActiveAddr);
    // word index, attribute slots at 0x00..0x3C
    assign wrIdx = paddr[spriteIdxBits+1:2];
    assign rdIdx = paddr[spriteIdxBits+1:2];
    assign wrData = pwdata;
    assign wrEn = access && pwrite && !addrErr && !isActive;
    // active sprite register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            activeIdx <= '0;
        end else if (access && pwrite && isActive) begin
            activeIdx <= pwdata[spriteIdxBits-1:0];
        end
    end
    // read mux, memory word arrives in access phase
    always_comb begin
        if (addrErr) begin
            prdata = '0;
        end else if (isActive) begin
            prdata = {{(apbDataBits - spriteIdxBits){1'b0}}, activeIdx};
        end else begin
            prdata = rdData;
        end
    end
    assign pready = 1'b1;
    assign pslverr = access && addrErr;
    // protocol: enable only within a selected transfer
    assert property (@(posedge clk) disable iff (!rstn) $rose(penable) |-> psel)
        else $error("penable rose without psel");
    // rejected transfers never reach the memory
    assert property (@(posedge clk) disable iff (!rstn) !(wrEn && pslverr))
        else $error("write issued on an error transfer");
endmodule

// File: verilog/spriteAttrRam.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sixteen attribute words, one write port
// two registered read ports, old data on collision
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module spriteAttrRam (
    input  logic clk,
    input  logic rstn,
    input  logic wrEn,
    input  logic [spritePkg::spriteIdxBits-1:0] wrIdx,
    input  logic [spritePkg::apbDataBits-1:0] wrData,
    input  logic [spritePkg::spriteIdxBits-1:0] apbIdx,
    output logic [spritePkg::apbDataBits-1:0] apbData,
    input  logic [spritePkg::spriteIdxBits-1:0] renderIdx,
    output spritePkg::spriteAttrT renderAttr
);
    import spritePkg::*;
    spriteAttrT mem [0:spriteNum-1];
    // write side, whole table cleared on reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < spriteNum; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[wrIdx].raw <= wrData;
        end
    end
    // read ports
    always_ff @(posedge clk) begin
        apbData <= mem[apbIdx].raw;
        renderAttr <= mem[renderIdx];
    end
endmodule

// File: verilog/tilePatternRom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64 tiles of 8x8, two bitplanes per word
// contents fixed at elaboration, one cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module tilePatternRom (
    input  logic clk,
    input  logic [spritePkg::tileIdxBits-1:0] tileIdx,
    output logic [spritePkg::tileDataBits-1:0] tileData
);
    import spritePkg::*;
    logic [tileDataBits-1:0] rom [0:tileNum-1];
    // build tiles from the pattern rule
    initial begin
        int code;
        int bitPos;
        for (int t = 0; t < tileNum; t++) begin
            rom[t] = '0;
            for (int y = 0; y < tileH; y++) begin
                for (int x = 0; x < tileW; x++) begin
                    code = (x + y + t) & 3;
                    bitPos = x + tileW * y;
                    // high plane then low plane
                    rom[t][127 - bitPos] = code[1];
                    rom[t][63 - bitPos] = code[0];
                end
            end
        end
    end
    always_ff @(posedge clk) begin
        tileData <= rom[tileIdx];
    end
endmodule

// File: verilog/tileDraw.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single sprite renderer, two stage pipeline
// rgb for a scan position appears 2 clocks later
// sprite clipped at raster edges, never wraps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module tileDraw (
    input  logic clk,
    input  logic rstn,
    scanIf.sink scan,
    input  spritePkg::spriteAttrT attr,
    output logic [spritePkg::tileIdxBits-1:0] tileIdx,
    input  logic [spritePkg::tileDataBits-1:0] tileData,
    output logic [spritePkg::posBits-1:0] pixX,
    output logic [spritePkg::posBits-1:0] pixY,
    output logic pixValid,
    output logic spriteHit,
    output logic [spritePkg::rgbBits-1:0] rgb
);
    import spritePkg::*;
    // stage 0, combinational
    logic [relBits-1:0] relX;
    logic [relBits-1:0] relY;
    logic inBox;
    logic [2:0] offX;
    logic [2:0] offY;
    // stage 1 registers
    logic valid1;
    logic hit1;
    logic [posBits-1:0] posX1;
    logic [posBits-1:0] posY1;
    logic [5:0] bit1;
    logic [1:0] pal1;
    // stage 2 decode
    logic [1:0] code;
    logic [3:0] palIdx;
    logic opaque;

    // ROM address straight from attribute, data lines up with stage 1
    assign tileIdx = attr.fields.tileIdx;
    // sprite relative position, negative values land far above the box
    assign relX = relBits'(scan.posX) - relBits'(gameStartX) - relBits'(attr.fields.posX);
    assign relY = relBits'(scan.posY) - relBits'(gameStartY) - relBits'(attr.fields.posY);
    assign inBox = scan.active && (relX < relBits'(tileW)) && (relY < relBits'(tileH));
    // mirroring
    assign offX = attr.fields.hFlip ? 3'd7 - relX[2:0] : relX[2:0];
    assign offY = attr.fields.vFlip ? 3'd7 - relY[2:0] : relY[2:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid1 <= 1'b0;
            hit1 <= 1'b0;
        end else begin
            valid1 <= scan.active;
            hit1 <= inBox;
        end
    end
    always_ff @(posedge clk) begin
        posX1 <= scan.posX;
        posY1 <= scan.posY;
        // bit index x + 8y
        bit1 <= {offY, offX};
        pal1 <= attr.fields.palSel;
    end

    // plane bits, high plane in upper half
    assign code = {tileData[7'd127 - {1'b0, bit1}], tileData[7'd63 - {1'b0, bit1}]};
    assign opaque = hit1 && (code != 2'b00);
    // table entry 3*pal + code - 1
    assign palIdx = {2'b00, pal1} * 4'd3 + {2'b00, code} - 4'd1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pixValid <= 1'b0;
            spriteHit <= 1'b0;
        end else begin
            pixValid <= valid1;
            spriteHit <= opaque;
        end
    end
    always_ff @(posedge clk) begin
        pixX <= posX1;
        pixY <= posY1;
        rgb <= opaque ? paletteTable[palIdx] : bgColor;
    end

    // frame start marker leaves the pipeline as visible pixel 0,0
    assert property (@(posedge clk) disable iff (!rstn)
        scan.frameStart |-> ##2 (pixValid && pixX == '0 && pixY == '0))
        else $error("frame start did not come out as pixel 0,0");
endmodule

// File: verilog/spriteDisplay.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite display top, APB config plus pixel output
// pixel stream has no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module spriteDisplay (
    input  logic clk,
    input  logic rstn,
    input  logic [spritePkg::apbAddrBits-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [spritePkg::apbDataBits-1:0] pwdata,
    output logic [spritePkg::apbDataBits-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [spritePkg::posBits-1:0] pixX,
    output logic [spritePkg::posBits-1:0] pixY,
    output logic pixValid,
    output logic spriteHit,
    output logic [spritePkg::rgbBits-1:0] rgb
);
    import spritePkg::*;
    // config path
    logic wrEn;
    logic [spriteIdxBits-1:0] wrIdx;
    logic [apbDataBits-1:0] wrData;
    logic [spriteIdxBits-1:0] rdIdx;
    logic [apbDataBits-1:0] rdData;
    logic [spriteIdxBits-1:0] activeIdx;
    // render path
    spriteAttrT renderAttr;
    logic [tileIdxBits-1:0] tileIdx;
    logic [tileDataBits-1:0] tileData;

    scanIf scanBus ();

    scanPosGen uScanGen (.clk(clk), .rstn(rstn), .scan(scanBus));

    apbSpriteRegs uRegs (
        .clk(clk), .rstn(rstn), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
        .rdIdx(rdIdx), .rdData(rdData), .activeIdx(activeIdx)
    );

    spriteAttrRam uAttrRam (
        .clk(clk), .rstn(rstn), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
        .apbIdx(rdIdx), .apbData(rdData), .renderIdx(activeIdx), .renderAttr(renderAttr)
    );

    tilePatternRom uRom (.clk(clk), .tileIdx(tileIdx), .tileData(tileData));

    tileDraw uDraw (
        .clk(clk), .rstn(rstn), .scan(scanBus), .attr(renderAttr), .tileIdx(tileIdx),
        .tileData(tileData), .pixX(pixX), .pixY(pixY), .pixValid(pixValid),
        .spriteHit(spriteHit), .rgb(rgb)
    );
endmodule

// File: dv/spriteDisplayTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite display testbench, fixed seed stimulus
// APB traffic only in vertical blanking, so the
// pixel model never sees a half applied attribute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
module spriteDisplayTb;
    import spritePkg::*;
    // frames the sequence runs through, with slack
    localparam int frameBudget = 24;
    localparam int clkPeriod = 4;

    logic clk;
    logic rstn;
    logic [apbAddrBits-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apbDataBits-1:0] pwdata;
    logic [apbDataBits-1:0] prdata;
    logic pready;
    logic pslverr;
    logic [posBits-1:0] pixX;
    logic [posBits-1:0] pixY;
    logic pixValid;
    logic spriteHit;
    logic [rgbBits-1:0] rgb;

    // reference state
    logic [31:0] rngState = 32'h5166aa97;
    spriteAttrT attrMirror [0:spriteNum-1];
    logic [spriteIdxBits-1:0] activeMirror;
    logic [rgbBits:0] expPix;
    // raster index on the scan bus, then 1 and 2 clocks later
    int scanRef = 0;
    int lagRef [0:1] = '{-1, -1};
    int refX;
    int refY;
    logic refValid;
    int apbErrs = 0;
    int pixErrs = 0;
    int pixCount = 0;
    int hitCount = 0;

    spriteDisplay DUT (
        .clk(clk), .rstn(rstn), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .pixX(pixX), .pixY(pixY), .pixValid(pixValid),
        .spriteHit(spriteHit), .rgb(rgb)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // xorshift32 step
    function automatic logic [31:0] nextRand();
        logic [31:0] s;
        s = rngState;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rngState = s;
        return s;
    endfunction

    // expected {hit, rgb} for a visible pixel
    function automatic logic [rgbBits:0] modelPixel(input int x, input int y);
        spriteAttrT a;
        int dx;
        int dy;
        int code;
        a = attrMirror[activeMirror];
        dx = x - gameStartX - int'(a.fields.posX);
        dy = y - gameStartY - int'(a.fields.posY);
        // outside the box, including anything past the raster edge
        if (dx < 0 || dx >= tileW || dy < 0 || dy >= tileH) begin
            return {1'b0, bgColor};
        end
        if (a.fields.hFlip) begin
            dx = tileW - 1 - dx;
        end
        if (a.fields.vFlip) begin
            dy = tileH - 1 - dy;
        end
        // tile pattern: code is (x + y + tile) mod 4
        code = (dx + dy + int'(a.fields.tileIdx)) % 4;
        if (code == 0) begin
            return {1'b0, bgColor};
        end
        return {1'b1, paletteTable[3 * int'(a.fields.palSel) + code - 1]};
    endfunction

    // one APB transfer, setup then access
    task automatic apbXfer(input logic wr, input logic [apbAddrBits-1:0] addr,
                           input logic [apbDataBits-1:0] wdata,
                           output logic [apbDataBits-1:0] rdata, output logic err);
        @(negedge clk);
        paddr = addr;
        pwdata = wdata;
        pwrite = wr;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // sample mid access phase
        #1;
        rdata = prdata;
        err = pslverr;
        assert (pready === 1'b1) else begin
            apbErrs++;
            $display("Fail %0t: pready low in access phase", $time);
        end
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic writeAttr(input int idx, input logic [apbDataBits-1:0] word);
        logic [apbDataBits-1:0] rd;
        logic err;
        apbXfer(1'b1, 8'(idx * 4), word, rd, err);
        assert (err === 1'b0) else begin
            apbErrs++;
            $display("Fail %0t: write to entry %0d flagged pslverr", $time, idx);
        end
        attrMirror[idx].raw = word;
    endtask

    task automatic setActive(input int idx);
        logic [apbDataBits-1:0] rd;
        logic err;
        apbXfer(1'b1, regActiveAddr, 32'(idx), rd, err);
        assert (err === 1'b0) else begin
            apbErrs++;
            $display("Fail %0t: active index write flagged pslverr", $time);
        end
        activeMirror = 4'(idx);
    endtask

    task automatic checkRead(input logic [apbAddrBits-1:0] addr,
                             input logic [apbDataBits-1:0] exp);
        logic [apbDataBits-1:0] rd;
        logic err;
        apbXfer(1'b0, addr, '0, rd, err);
        assert (err === 1'b0 && rd === exp) else begin
            apbErrs++;
            $display("Fail %0t: read 0x%h gave %h err %b, expected %h", $time, addr, rd, err, exp);
        end
    endtask

    // unmapped or unaligned, must answer with pslverr
    task automatic checkReject(input logic wr, input logic [apbAddrBits-1:0] addr);
        logic [apbDataBits-1:0] rd;
        logic err;
        apbXfer(wr, addr, nextRand(), rd, err);
        assert (err === 1'b1) else begin
            apbErrs++;
            $display("Fail %0t: access to 0x%h gave no pslverr", $time, addr);
        end
    endtask

    task automatic readBackAll();
        for (int i = 0; i < spriteNum; i++) begin
            checkRead(8'(i * 4), attrMirror[i].raw);
        end
        checkRead(regActiveAddr, 32'(activeMirror));
    endtask

    // random tile and reserved bits, caller picks the rest
    task automatic placeSprite(input int idx, input int x, input int y,
                               input logic [1:0] flips, input logic [1:0] pal);
        spriteAttrT a;
        a.raw = nextRand();
        a.fields.posX = 8'(x);
        a.fields.posY = 8'(y);
        a.fields.hFlip = flips[1];
        a.fields.vFlip = flips[0];
        a.fields.palSel = pal;
        writeAttr(idx, a.raw);
    endtask

    // last visible pixel out, vertical blanking follows
    task automatic waitFrameEnd();
        do begin
            @(negedge clk);
        end while (!(pixValid === 1'b1 && pixX == posBits'(hActive - 1)
                     && pixY == posBits'(vActive - 1)));
    endtask

    // reference raster, scan bus sits at 0,0 during reset
    always @(posedge clk) begin
        if (rstn !== 1'b1) begin
            scanRef = 0;
            lagRef[0] = -1;
            lagRef[1] = -1;
        end else begin
            // output carries the position from two clocks back
            lagRef[1] = lagRef[0];
            lagRef[0] = scanRef;
            scanRef = (scanRef + 1) % (hTotal * vTotal);
        end
    end

    // pixel monitor, every output cycle against the reference raster and model
    always @(negedge clk) begin
        refX = lagRef[1] % hTotal;
        refY = lagRef[1] / hTotal;
        refValid = (lagRef[1] >= 0) && (refX < hActive) && (refY < vActive);
        assert (pixValid === refValid) else begin
            pixErrs++;
            $display("Fail %0t: pixValid %b, expected %b at raster %0d,%0d",
                $time, pixValid, refValid, refX, refY);
        end
        if (refValid) begin
            expPix = modelPixel(refX, refY);
            pixCount++;
            assert (pixX === posBits'(refX) && pixY === posBits'(refY)) else begin
                pixErrs++;
                $display("Fail %0t: pixel position %0d,%0d, expected %0d,%0d",
                    $time, pixX, pixY, refX, refY);
            end
            assert (rgb === expPix[rgbBits-1:0] && spriteHit === expPix[rgbBits]) else begin
                pixErrs++;
                $display("Fail %0t: pixel %0d,%0d rgb %h hit %b, expected rgb %h hit %b",
                    $time, refX, refY, rgb, spriteHit, expPix[rgbBits-1:0], expPix[rgbBits]);
            end
            if (spriteHit === 1'b1) begin
                hitCount++;
            end
        end else begin
            assert (spriteHit === 1'b0) else begin
                pixErrs++;
                $display("Fail %0t: spriteHit high outside the visible area", $time);
            end
        end
    end

    initial begin
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        rstn = 1'b0;
        activeMirror = '0;
        for (int i = 0; i < spriteNum; i++) begin
            attrMirror[i] = '0;
        end
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        // fill the table, read it back
        waitFrameEnd();
        for (int i = 0; i < spriteNum; i++) begin
            writeAttr(i, nextRand());
        end
        setActive(int'(nextRand() % 16));
        readBackAll();

        // rejected accesses leave everything as it was
        waitFrameEnd();
        checkReject(1'b1, 8'h06);
        checkReject(1'b0, 8'h3A);
        checkReject(1'b1, 8'h41);
        checkReject(1'b1, 8'h42);
        checkReject(1'b1, 8'h44);
        checkReject(1'b1, 8'h80);
        checkReject(1'b1, 8'hFC);
        checkReject(1'b0, 8'h43);
        checkReject(1'b0, 8'h48);
        readBackAll();

        // random placement fully on screen, no flips
        repeat (3) begin
            waitFrameEnd();
            placeSprite(int'(activeMirror), int'(nextRand() % 52), int'(nextRand() % 38),
                        2'b00, 2'(nextRand()));
        end

        // each flip pair, each palette
        for (int i = 0; i < 8; i++) begin
            waitFrameEnd();
            placeSprite(int'(activeMirror), int'(nextRand() % 52), int'(nextRand() % 38),
                        2'(i), 2'(i >> 1));
        end

        // switch between two sprites
        waitFrameEnd();
        placeSprite(2, 10, 10, 2'b00, 2'd1);
        placeSprite(9, 40, 30, 2'b11, 2'd2);
        setActive(2);
        waitFrameEnd();
        setActive(9);
        // right and bottom edge clip, then far off screen
        waitFrameEnd();
        placeSprite(9, 56, 43, 2'b01, 2'd3);
        waitFrameEnd();
        placeSprite(9, 255, 250, 2'b10, 2'd0);
        waitFrameEnd();

        assert (hitCount > 0) else begin
            pixErrs++;
            $display("no sprite pixel was drawn during the whole run");
        end
        $display("errors: apb %0d, pixel %0d, pixels checked %0d", apbErrs, pixErrs, pixCount);
        if (apbErrs == 0 && pixErrs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the frame count
    initial begin
        #(frameBudget * hTotal * vTotal * clkPeriod + 2000);
        $display("watchdog expired before the sequence finished");
        $display("TEST FAILED");
        $finish;
    end
endmodule

// File: filelist.f
verilog/spritePkg.sv
verilog/scanIf.sv
verilog/scanPosGen.sv
verilog/apbSpriteRegs.sv
verilog/spriteAttrRam.sv
verilog/tilePatternRom.sv
verilog/tileDraw.sv
verilog/spriteDisplay.sv
dv/spriteDisplayTb.sv

// File: Makefile
TOP = spriteDisplayTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
